//--- compile.f
+incdir+verification
hdl/cache_pkg.sv
hdl/cache_line_store.sv
hdl/cache_controller.sv
hdl/cache_top.sv
verification/cache_tb_memory.sv
verification/cache_tb.sv

//--- verification/cache_tb_ops.svh
// processor operation table: stimulus, expected read data and memory traffic per entry
`ifndef cache_tb_ops_svh
`define cache_tb_ops_svh

// columns: is_write, word addr, write data, expected read data,
// hit expected in the request cycle, total memory reads and writes after the entry
typedef struct packed {
	logic        is_write;
	logic [29:0] addr;
	logic [31:0] wdata;
	logic [31:0] expected;
	logic        hit;
	logic [7:0]  reads;
	logic [7:0]  writes;
} op_entry_t;

localparam int num_ops = 30;

op_entry_t op_table [num_ops];

function automatic op_entry_t make_op(input logic is_write, input logic [29:0] addr,
		input logic [31:0] wdata, input logic [31:0] expected, input logic hit,
		input logic [7:0] reads, input logic [7:0] writes);
	op_entry_t e;
	e = {is_write, addr, wdata, expected, hit, reads, writes};
	return e;
endfunction

task automatic load_op_table();
	// index 1 line: cold miss, hits, dirty conflict, clean refill
	op_table[0]  = make_op(1'b0, 30'h004, 32'h0,         32'ha5a5_0004, 1'b0, 8'd1,  8'd0);
	op_table[1]  = make_op(1'b0, 30'h006, 32'h0,         32'ha5a5_0006, 1'b1, 8'd1,  8'd0);
	op_table[2]  = make_op(1'b1, 30'h005, 32'h1111_0005, 32'h0,         1'b1, 8'd1,  8'd0);
	op_table[3]  = make_op(1'b0, 30'h005, 32'h0,         32'h1111_0005, 1'b1, 8'd1,  8'd0);
	op_table[4]  = make_op(1'b0, 30'h004, 32'h0,         32'ha5a5_0004, 1'b1, 8'd1,  8'd0);
	op_table[5]  = make_op(1'b0, 30'h007, 32'h0,         32'ha5a5_0007, 1'b1, 8'd1,  8'd0);
	op_table[6]  = make_op(1'b0, 30'h024, 32'h0,         32'ha5a5_0024, 1'b0, 8'd2,  8'd1);
	op_table[7]  = make_op(1'b0, 30'h005, 32'h0,         32'h1111_0005, 1'b0, 8'd3,  8'd1);
	// index 4: write miss allocates, then dirty victim
	op_table[8]  = make_op(1'b1, 30'h010, 32'h2222_0010, 32'h0,         1'b0, 8'd4,  8'd1);
	op_table[9]  = make_op(1'b1, 30'h013, 32'h2222_0013, 32'h0,         1'b1, 8'd4,  8'd1);
	op_table[10] = make_op(1'b0, 30'h030, 32'h0,         32'ha5a5_0030, 1'b0, 8'd5,  8'd2);
	op_table[11] = make_op(1'b0, 30'h013, 32'h0,         32'h2222_0013, 1'b0, 8'd6,  8'd2);
	op_table[12] = make_op(1'b0, 30'h010, 32'h0,         32'h2222_0010, 1'b1, 8'd6,  8'd2);
	op_table[13] = make_op(1'b0, 30'h011, 32'h0,         32'ha5a5_0011, 1'b1, 8'd6,  8'd2);
	// index 7: two dirty blocks trade places
	op_table[14] = make_op(1'b1, 30'h03c, 32'h3333_003c, 32'h0,         1'b0, 8'd7,  8'd2);
	op_table[15] = make_op(1'b1, 30'h01e, 32'h3333_001e, 32'h0,         1'b0, 8'd8,  8'd3);
	op_table[16] = make_op(1'b1, 30'h01f, 32'h3333_001f, 32'h0,         1'b1, 8'd8,  8'd3);
	op_table[17] = make_op(1'b0, 30'h03c, 32'h0,         32'h3333_003c, 1'b0, 8'd9,  8'd4);
	op_table[18] = make_op(1'b0, 30'h01e, 32'h0,         32'h3333_001e, 1'b0, 8'd10, 8'd4);
	op_table[19] = make_op(1'b0, 30'h01f, 32'h0,         32'h3333_001f, 1'b1, 8'd10, 8'd4);
	op_table[20] = make_op(1'b0, 30'h01c, 32'h0,         32'ha5a5_001c, 1'b1, 8'd10, 8'd4);
	// index 2 with a far tag
	op_table[21] = make_op(1'b1, 30'h008, 32'h4444_0008, 32'h0,         1'b0, 8'd11, 8'd4);
	op_table[22] = make_op(1'b0, 30'h008, 32'h0,         32'h4444_0008, 1'b1, 8'd11, 8'd4);
	op_table[23] = make_op(1'b0, 30'h0a8, 32'h0,         32'ha5a5_00a8, 1'b0, 8'd12, 8'd5);
	op_table[24] = make_op(1'b1, 30'h0ab, 32'h4444_00ab, 32'h0,         1'b1, 8'd12, 8'd5);
	op_table[25] = make_op(1'b0, 30'h009, 32'h0,         32'ha5a5_0009, 1'b0, 8'd13, 8'd6);
	op_table[26] = make_op(1'b0, 30'h008, 32'h0,         32'h4444_0008, 1'b1, 8'd13, 8'd6);
	op_table[27] = make_op(1'b0, 30'h0ab, 32'h0,         32'h4444_00ab, 1'b0, 8'd14, 8'd6);
	op_table[28] = make_op(1'b0, 30'h000, 32'h0,         32'ha5a5_0000, 1'b0, 8'd15, 8'd6);
	op_table[29] = make_op(1'b0, 30'h024, 32'h0,         32'ha5a5_0024, 1'b0, 8'd16, 8'd6);
endtask

`endif

//--- verification/cache_tb.sv
// cache testbench driving the operation table and checking read data and memory traffic
`timescale 1ns/100ps

module cache_tb;
	import cache_pkg::*;

	`include "cache_tb_ops.svh"

	localparam int unsigned index_bits = 3;
	localparam int clk_period   = 100;
	localparam int drive_delay  = 5;
	localparam int reset_cycles = 16;
	localparam int cycle_limit  = num_ops * 24 + reset_cycles;
	localparam int shadow_words = 1024;
	localparam int num_lines    = 1 << index_bits;

	logic      clk;
	logic      proc_reset;
	proc_req_t proc_req;
	logic      stall;
	word_t     rdata;
	mem_req_t  mem_req;
	line_t     mem_rdata;
	logic      mem_ready;
	logic      mem_model_error;

	word_t     shadow_mem [shadow_words];  // expected contents of cache and memory together
	logic [block_addr_bits-1:0] resident_block [num_lines];  // block last filled per index
	int        cycle_count;

	cache_top #(
		.index_bits (index_bits)
	) i_cache_top (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_req   (proc_req),
		.stall      (stall),
		.rdata      (rdata),
		.mem_req    (mem_req),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	cache_tb_memory #(
		.drive_delay (drive_delay)
	) i_cache_tb_memory (
		.clk            (clk),
		.proc_reset     (proc_reset),
		.mem_req        (mem_req),
		.mem_rdata      (mem_rdata),
		.mem_ready      (mem_ready),
		.protocol_error (mem_model_error)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	function automatic word_t initial_word(input logic [word_addr_bits-1:0] a);
		return {2'b00, a} ^ 32'ha5a5_0000;  // memory content rule
	endfunction

	task automatic fail_run();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input logic [127:0] got,
			input logic [127:0] expected);
		if (got !== expected) begin
			$display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, expected);
			fail_run();
		end
	endtask

	task automatic apply_op(input int n);
		op_entry_t                  op;
		int                         wait_cycles;
		int                         prev_reads;
		int                         prev_writes;
		logic [index_bits-1:0]      line_index;
		logic [block_addr_bits-1:0] wb_block;
		line_t                      shadow_line;
		bit                         done;
		op          = op_table[n];
		line_index  = op.addr[offset_bits +: index_bits];
		prev_reads  = i_cache_tb_memory.read_count;
		prev_writes = i_cache_tb_memory.write_count;
		@(posedge clk);
		#drive_delay;
		proc_req.read  = !op.is_write;
		proc_req.write = op.is_write;
		proc_req.addr  = op.addr;
		proc_req.wdata = op.wdata;
		done        = 1'b0;
		wait_cycles = 0;
		while (!done) begin
			@(negedge clk);
			if (wait_cycles == 0) begin
				check_value($sformatf("entry %0d stall in request cycle", n), stall, !op.hit);
			end
			if (!stall) begin
				done = 1'b1;
			end else begin
				wait_cycles++;  // request stays held
			end
		end
		if (!op.is_write) begin
			check_value($sformatf("entry %0d table vs shadow", n), op.expected,
				shadow_mem[op.addr]);
			check_value($sformatf("entry %0d read data", n), rdata, op.expected);
		end
		check_value($sformatf("entry %0d memory reads", n), i_cache_tb_memory.read_count,
			op.reads);
		check_value($sformatf("entry %0d memory writes", n), i_cache_tb_memory.write_count,
			op.writes);
		if (i_cache_tb_memory.read_count != prev_reads) begin
			check_value($sformatf("entry %0d refill block", n),
				i_cache_tb_memory.last_read_block, op.addr[word_addr_bits-1:offset_bits]);
		end
		// victim is the block last filled at this index, with its latest words
		if (i_cache_tb_memory.write_count != prev_writes) begin
			wb_block = resident_block[line_index];
			check_value($sformatf("entry %0d write-back block", n),
				i_cache_tb_memory.last_wb_block, wb_block);
			for (int w = 0; w < words_per_line; w++) begin
				shadow_line[w*32 +: 32] = shadow_mem[{wb_block, w[1:0]}];
			end
			check_value($sformatf("entry %0d write-back data", n),
				i_cache_tb_memory.last_wb_data, shadow_line);
		end
		if (i_cache_tb_memory.read_count != prev_reads) begin
			resident_block[line_index] = op.addr[word_addr_bits-1:offset_bits];
		end
		if (op.is_write) begin
			shadow_mem[op.addr] = op.wdata;
		end
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		proc_reset = 1'b1;
		proc_req   = '0;
		for (int a = 0; a < shadow_words; a++) begin
			shadow_mem[a] = initial_word(a[word_addr_bits-1:0]);
		end
		for (int i = 0; i < num_lines; i++) begin
			resident_block[i] = '0;
		end
		load_op_table();
		repeat (reset_cycles) @(posedge clk);
		#drive_delay;
		proc_reset = 1'b0;
		@(negedge clk);
		check_value("stall after reset", stall, 1'b0);
		check_value("memory read after reset", mem_req.read, 1'b0);
		check_value("memory write after reset", mem_req.write, 1'b0);
		for (int n = 0; n < num_ops; n++) begin
			apply_op(n);
		end
		@(posedge clk);
		#drive_delay;
		proc_req = '0;
		@(negedge clk);
		check_value("stall with no request", stall, 1'b0);
		$display("Test completed successfully");
		$finish;
	end

	// run limit
	initial begin
		cycle_count = 0;
		forever begin
			@(posedge clk);
			cycle_count++;
			if (cycle_count >= cycle_limit) begin
				$display("The run timed out after %0d cycles before the table finished",
					cycle_count);
				fail_run();
			end
		end
	end

	initial begin
		wait (mem_model_error === 1'b1);
		$display("The block memory model saw a protocol problem: %s",
			i_cache_tb_memory.error_msg);
		fail_run();
	end

endmodule

//--- verification/cache_tb_memory.sv
// block memory model: 128-bit lines, held request, one-cycle ready after random latency
`timescale 1ns/100ps

module cache_tb_memory #(
	parameter int drive_delay = 5
) (
	input  logic                clk,
	input  logic                proc_reset,
	input  cache_pkg::mem_req_t mem_req,
	output cache_pkg::line_t    mem_rdata,
	output logic                mem_ready,
	output logic                protocol_error
);
	import cache_pkg::*;

	localparam int mem_blocks = 256;

	line_t                      mem_lines [mem_blocks];
	logic [31:0]                lfsr_state;
	int                         read_count;
	int                         write_count;
	logic [block_addr_bits-1:0] last_read_block;
	logic [block_addr_bits-1:0] last_wb_block;   // most recent write-back
	line_t                      last_wb_data;
	string                      error_msg;
	mem_req_t                   held_req;
	int                         latency;

	function automatic word_t initial_word(input logic [word_addr_bits-1:0] a);
		return {2'b00, a} ^ 32'ha5a5_0000;
	endfunction

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_latency(output int lat);
		lat = 0;
		for (int b = 0; b < 3; b++) begin
			lfsr_state = lfsr_next(lfsr_state);  // one step per bit
			lat = (lat << 1) | lfsr_state[0];
		end
	endtask

	task automatic check_held(input mem_req_t expected_req);
		if (mem_req !== expected_req) begin
			error_msg      = "memory request changed before mem_ready";
			protocol_error = 1'b1;
		end
	endtask

	// ------------------------------------------------------------
	// request service: sample at negedge, drive after posedge
	// ------------------------------------------------------------
	initial begin
		lfsr_state     = 32'hfeba;
		mem_ready      = 1'b0;
		mem_rdata      = '0;
		protocol_error = 1'b0;
		read_count     = 0;
		write_count    = 0;
		for (int b = 0; b < mem_blocks; b++) begin
			for (int w = 0; w < words_per_line; w++) begin
				mem_lines[b][w*32 +: 32] = initial_word({b[block_addr_bits-1:0], w[1:0]});
			end
		end
		forever begin
			@(negedge clk);
			if (!proc_reset && (mem_req.read || mem_req.write)) begin
				held_req = mem_req;
				if (held_req.block_addr >= mem_blocks) begin
					error_msg      = "memory request outside the modeled block range";
					protocol_error = 1'b1;
				end
				draw_latency(latency);
				repeat (latency) begin
					@(negedge clk);
					check_held(held_req);
				end
				@(posedge clk);
				#drive_delay;
				mem_ready = 1'b1;
				if (held_req.read) begin
					mem_rdata       = mem_lines[held_req.block_addr[7:0]];
					read_count      = read_count + 1;
					last_read_block = held_req.block_addr;
				end else begin
					mem_lines[held_req.block_addr[7:0]] = held_req.wdata;
					write_count   = write_count + 1;
					last_wb_block = held_req.block_addr;
					last_wb_data  = held_req.wdata;
				end
				@(negedge clk);
				check_held(held_req);  // still held in the ready cycle
				@(posedge clk);
				#drive_delay;
				mem_ready = 1'b0;
			end
		end
	end

endmodule

//--- hdl/cache_top.sv
// cache top: direct-mapped write-back data cache, controller plus line store
`timescale 1ns/100ps

module cache_top #(
	parameter int unsigned index_bits = 3
) (
	input  logic                 clk,
	input  logic                 proc_reset,
	// processor side
	input  cache_pkg::proc_req_t proc_req,
	output logic                 stall,
	output cache_pkg::word_t     rdata,
	// block memory side
	output cache_pkg::mem_req_t  mem_req,
	input  cache_pkg::line_t     mem_rdata,
	input  logic                 mem_ready
);
	import cache_pkg::*;

	localparam int unsigned tag_bits = word_addr_bits - index_bits - offset_bits;

	// ------------------------------------------------------------
	// controller to store
	// ------------------------------------------------------------
	logic [index_bits-1:0]  index;
	logic [offset_bits-1:0] offset;
	logic                   word_we;
	word_t                  word_wdata;
	logic                   fill_en;
	logic [tag_bits-1:0]    fill_tag;
	line_t                  fill_data;

	// store back to controller
	logic                   line_valid;
	logic                   line_dirty;
	logic [tag_bits-1:0]    line_tag;
	line_t                  line_data;

	cache_controller #(
		.index_bits (index_bits)
	) i_cache_controller (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_req   (proc_req),
		.stall      (stall),
		.line_valid (line_valid),
		.line_dirty (line_dirty),
		.line_tag   (line_tag),
		.line_data  (line_data),
		.index      (index),
		.offset     (offset),
		.word_we    (word_we),
		.word_wdata (word_wdata),
		.fill_en    (fill_en),
		.fill_tag   (fill_tag),
		.fill_data  (fill_data),
		.mem_req    (mem_req),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	cache_line_store #(
		.index_bits (index_bits)
	) i_cache_line_store (
		.clk        (clk),
		.proc_reset (proc_reset),
		.index      (index),
		.offset     (offset),
		.word_we    (word_we),
		.word_wdata (word_wdata),
		.fill_en    (fill_en),
		.fill_tag   (fill_tag),
		.fill_data  (fill_data),
		.line_valid (line_valid),
		.line_dirty (line_dirty),
		.line_tag   (line_tag),
		.line_data  (line_data),
		.rd_word    (rdata)  // read data straight from the store
	);

endmodule

//--- hdl/cache_controller.sv
// cache controller: hit test, miss FSM, stall and block memory requests
`timescale 1ns/100ps

module cache_controller #(
	parameter int unsigned index_bits = 3
) (
	input  logic                                clk,
	input  logic                                proc_reset,
	// processor side
	input  cache_pkg::proc_req_t                proc_req,
	output logic                                stall,
	// indexed line from the store
	input  logic                                line_valid,
	input  logic                                line_dirty,
	input  logic [cache_pkg::word_addr_bits-index_bits-cache_pkg::offset_bits-1:0] line_tag,
	input  cache_pkg::line_t                    line_data,
	// store select and write controls
	output logic [index_bits-1:0]               index,
	output logic [cache_pkg::offset_bits-1:0]   offset,
	output logic                                word_we,
	output cache_pkg::word_t                    word_wdata,
	output logic                                fill_en,
	output logic [cache_pkg::word_addr_bits-index_bits-cache_pkg::offset_bits-1:0] fill_tag,
	output cache_pkg::line_t                    fill_data,
	// block memory side
	output cache_pkg::mem_req_t                 mem_req,
	input  cache_pkg::line_t                    mem_rdata,
	input  logic                                mem_ready
);
	import cache_pkg::*;

	localparam int unsigned tag_bits = word_addr_bits - index_bits - offset_bits;

	ctrl_state_t         state_r;
	ctrl_state_t         state_nx;
	logic [tag_bits-1:0] req_tag;
	logic                req_valid;
	logic                hit;

	// ------------------------------------------------------------
	// address split and hit test
	// ------------------------------------------------------------
	assign req_tag = proc_req.addr[word_addr_bits-1 -: tag_bits];
	assign index   = proc_req.addr[offset_bits +: index_bits];
	assign offset  = proc_req.addr[offset_bits-1:0];

	// exactly one of read or write, anything else is dropped
	assign req_valid = proc_req.read ^ proc_req.write;
	assign hit       = line_valid && (line_tag == req_tag);

	// payload paths, qualified by the enables below
	assign word_wdata = proc_req.wdata;
	assign fill_tag   = req_tag;
	assign fill_data  = mem_rdata;

	// ------------------------------------------------------------
	// miss FSM
	// ------------------------------------------------------------
	always_ff @(posedge clk or posedge proc_reset) begin
		if (proc_reset) begin
			state_r <= idle;
		end else begin
			state_r <= state_nx;
		end
	end

	always_comb begin
		state_nx           = state_r;
		stall              = 1'b0;
		word_we            = 1'b0;
		fill_en            = 1'b0;
		mem_req.read       = 1'b0;
		mem_req.write      = 1'b0;
		mem_req.block_addr = {req_tag, index};
		mem_req.wdata      = line_data;  // victim line for write-back

		case (state_r)
			idle: begin
				if (req_valid) begin
					if (hit) begin
						word_we = proc_req.write;  // write hit lands at this edge
					end else begin
						stall = 1'b1;
						// only a valid line can be dirty
						if (line_valid && line_dirty) begin
							state_nx = write_back;
						end else begin
							state_nx = refill;
						end
					end
				end
			end

			write_back: begin
				stall              = 1'b1;
				mem_req.write      = 1'b1;
				mem_req.block_addr = {line_tag, index};  // old block
				if (mem_ready) begin
					state_nx = refill;
				end
			end

			refill: begin
				stall        = 1'b1;
				mem_req.read = 1'b1;
				if (mem_ready) begin
					fill_en  = 1'b1;  // line valid and clean
					state_nx = idle;  // held request hits next cycle
				end
			end

			default: begin
				state_nx = idle;
			end
		endcase
	end

	// ------------------------------------------------------------
	// memory handshake checks
	// ------------------------------------------------------------
	a_mem_one_cmd: assert property (
		@(posedge clk) disable iff (proc_reset)
		!(mem_req.read && mem_req.write)
	) else $error("memory read and write requested together");

	// relies on the processor holding its request under stall
	a_mem_req_held: assert property (
		@(posedge clk) disable iff (proc_reset)
		(mem_req.read || mem_req.write) && !mem_ready |=> $stable(mem_req)
	) else $error("memory request changed before mem_ready");

endmodule

//--- hdl/cache_line_store.sv
// cache line store: valid, dirty, tag and data per line, word write and line fill
`timescale 1ns/100ps

module cache_line_store #(
	parameter int unsigned index_bits = 3
) (
	input  logic                                clk,
	input  logic                                proc_reset,
	// line and word select
	input  logic [index_bits-1:0]               index,
	input  logic [cache_pkg::offset_bits-1:0]   offset,
	// processor word write on a hit
	input  logic                                word_we,
	input  cache_pkg::word_t                    word_wdata,
	// refill from block memory
	input  logic                                fill_en,
	input  logic [cache_pkg::word_addr_bits-index_bits-cache_pkg::offset_bits-1:0] fill_tag,
	input  cache_pkg::line_t                    fill_data,
	// indexed line status
	output logic                                line_valid,
	output logic                                line_dirty,
	output logic [cache_pkg::word_addr_bits-index_bits-cache_pkg::offset_bits-1:0] line_tag,
	output cache_pkg::line_t                    line_data,
	output cache_pkg::word_t                    rd_word
);
	import cache_pkg::*;

	localparam int unsigned tag_bits  = word_addr_bits - index_bits - offset_bits;
	localparam int unsigned num_lines = 1 << index_bits;
	localparam int unsigned word_bits = $bits(word_t);

	// ------------------------------------------------------------
	// storage
	// ------------------------------------------------------------
	logic [num_lines-1:0] valid_r;  // one bit per line
	logic [num_lines-1:0] dirty_r;
	logic [tag_bits-1:0]  tag_mem  [num_lines];
	line_t                data_mem [num_lines];

	// status bits
	always_ff @(posedge clk or posedge proc_reset) begin
		if (proc_reset) begin
			valid_r <= '0;  // every line invalid
			dirty_r <= '0;
		end else if (fill_en) begin
			valid_r[index] <= 1'b1;
			dirty_r[index] <= 1'b0;  // fresh copy of memory
		end else if (word_we) begin
			dirty_r[index] <= 1'b1;
		end
	end

	// tag and data arrays
	always_ff @(posedge clk) begin
		if (fill_en) begin
			tag_mem[index]  <= fill_tag;
			data_mem[index] <= fill_data;
		end else if (word_we) begin
			data_mem[index][offset*word_bits +: word_bits] <= word_wdata;  // one word only
		end
	end

	// ------------------------------------------------------------
	// read side, all combinational
	// ------------------------------------------------------------
	assign line_valid = valid_r[index];
	assign line_dirty = dirty_r[index];
	assign line_tag   = tag_mem[index];
	assign line_data  = data_mem[index];

	// word select from the indexed line
	assign rd_word = line_data[offset*word_bits +: word_bits];

	// controller only fills outside idle and only writes words in idle
	a_no_fill_and_write: assert property (
		@(posedge clk) disable iff (proc_reset)
		!(word_we && fill_en)
	) else $error("word write and line fill in the same cycle");

endmodule

//--- hdl/cache_pkg.sv
// cache package: address widths, data types, request structs and controller states
package cache_pkg;

	// ------------------------------------------------------------
	// address geometry
	// ------------------------------------------------------------
	localparam int unsigned word_addr_bits  = 30;  // processor word address
	localparam int unsigned offset_bits     = 2;   // word select inside a line
	localparam int unsigned words_per_line  = 1 << offset_bits;
	localparam int unsigned block_addr_bits = word_addr_bits - offset_bits;  // 28

	// ------------------------------------------------------------
	// data types
	// ------------------------------------------------------------
	typedef logic [31:0] word_t;

	// word 0 sits in the low bits
	typedef logic [words_per_line*$bits(word_t)-1:0] line_t;

	// processor request, exactly one of read or write for a valid access
	typedef struct packed {
		logic                      read;
		logic                      write;
		logic [word_addr_bits-1:0] addr;
		word_t                     wdata;
	} proc_req_t;

	// block memory request, held until mem_ready
	typedef struct packed {
		logic                       read;
		logic                       write;
		logic [block_addr_bits-1:0] block_addr;
		line_t                      wdata;
	} mem_req_t;

	// ------------------------------------------------------------
	// miss handling states
	// ------------------------------------------------------------
	typedef enum logic [1:0] {
		idle       = 2'd0,  // hits served here
		write_back = 2'd1,  // dirty victim goes out
		refill     = 2'd2   // new block comes in
	} ctrl_state_t;

endpackage
